// File: design/hex_config.svh
// geometry and bus widths for the hex overlay
// HEX_DATA_BITS must equal HEX_ROWS*HEX_COLS*4 and be a multiple of 32
// HEX_WB_ADDR_BITS must reach the control word at HEX_DATA_BITS/32
`ifndef HEX_CONFIG_SVH
`define HEX_CONFIG_SVH

// frame geometry
`define HEX_ROWS 2          // character rows per frame
`define HEX_COLS 16         // digits per character row
`define HEX_SCANLINES 8     // scanlines per glyph, last one blank
`define HEX_CHAR_PIXELS 6   // 5 glyph pixels + 1 spacer

// displayed value, one nibble per digit
`define HEX_DATA_BITS 128

// wishbone word address, data words then control word
`define HEX_WB_ADDR_BITS 3

`endif

// File: design/hex_pkg.sv
// pixel and glyph types for the hex overlay, RGB332 only
// glyph lines are stored with bit 0 as the leftmost screen pixel
package hex_pkg;

  typedef logic [7:0] color_t;       // RGB332, rrr_ggg_bb
  typedef logic [3:0] nibble_t;      // one hex digit
  typedef logic [4:0] glyph_line_t;  // one glyph scanline, bit 0 leftmost

  // glyph foreground
  localparam color_t COLOR_WHITE = 8'hFF;

  // digit background, indexed by the digit value
  // red steps 20/40/80, green 04/08/10, blue 01/02
  localparam color_t BG_COLORS [16] = '{
    8'h00,  // 0 black
    8'h40,  // 1 dark red
    8'h44,  // 2 dark brown
    8'h48,  // 3 dark yellow
    8'h08,  // 4 dark green
    8'h05,  // 5 dark cyan
    8'h01,  // 6 dark blue
    8'h21,  // 7 dark violet
    8'h45,  // 8 gray
    8'h80,  // 9 light red
    8'h84,  // A orange
    8'h90,  // B light yellow
    8'h10,  // C light green
    8'h0A,  // D light cyan
    8'h02,  // E light blue
    8'h42   // F light violet
  };

endpackage

// File: design/wb_hex_regs.sv
// wishbone classic slave, 32-bit, one wait state per access
// words 0..3 hold the value LSW first, word 4 is control (bit 0 hold)
// unmapped words read 0 and drop writes, no err or rty
`timescale 1ns/100ps
`include "hex_config.svh"

module wb_hex_regs (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`HEX_WB_ADDR_BITS-1:0]  wb_adr,
  input  logic [31:0]                   wb_dat_w,
  input  logic [3:0]                    wb_sel,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack,
  output logic [`HEX_DATA_BITS-1:0]     data_value,
  output logic                          hold
);

  localparam int NUM_WORDS = `HEX_DATA_BITS / 32;
  localparam logic [`HEX_WB_ADDR_BITS-1:0] CTRL_ADR = `HEX_WB_ADDR_BITS'(NUM_WORDS);

  logic [31:0] data_words [NUM_WORDS];
  logic        access;   // cycle accepted this clock
  logic        wr_en;
  logic [31:0] rd_word;

  assign access = wb_cyc && wb_stb && !wb_ack; // ack low means not yet served
  assign wr_en  = access && wb_we;

  // ack follows the request by one clock and drops right after
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      wb_ack <= 1'b0;
    else
      wb_ack <= access;
  end

  genvar w;
  generate
    for (w = 0; w < NUM_WORDS; w++)
    begin : g_word
      always_ff @(posedge clk or negedge arst_n)
      begin
        if (!arst_n)
          data_words[w] <= '0;
        else if (wr_en && wb_adr == `HEX_WB_ADDR_BITS'(w))
        begin
          for (int b = 0; b < 4; b++)
            if (wb_sel[b])
              data_words[w][8*b +: 8] <= wb_dat_w[8*b +: 8]; // byte lane b
        end
      end
      assign data_value[32*w +: 32] = data_words[w];
    end
  endgenerate

  // control word, only hold is stored
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      hold <= 1'b0;
    else if (wr_en && wb_adr == CTRL_ADR && wb_sel[0])
      hold <= wb_dat_w[0];
  end

  always_comb
  begin
    rd_word = '0; // unmapped default
    for (int i = 0; i < NUM_WORDS; i++)
      if (wb_adr == `HEX_WB_ADDR_BITS'(i))
        rd_word = data_words[i];
    if (wb_adr == CTRL_ADR)
      rd_word = {31'b0, hold};
  end

  // read data valid together with ack
  always_ff @(posedge clk)
  begin
    if (access)
      wb_dat_r <= rd_word;
  end

endmodule

// File: design/glyph_scan_sequencer.sv
// frame walk, one position per pixel_step, no skipping
// next_digit/next_scanline name the digit after the one on screen,
// except before the first step where they name digit (0,0) itself
`timescale 1ns/100ps
`include "hex_config.svh"

module glyph_scan_sequencer (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        pixel_step,
  input  logic [`HEX_DATA_BITS-1:0]   data_value,
  input  logic                        hold,
  output hex_pkg::nibble_t            next_digit,
  output logic [2:0]                  next_scanline,
  output logic                        char_done
);

  localparam int K_W   = $clog2(`HEX_CHAR_PIXELS);
  localparam int COL_W = $clog2(`HEX_COLS);
  localparam int ROW_W = $clog2(`HEX_ROWS);
  localparam int DIG_W = $clog2(`HEX_ROWS * `HEX_COLS);
  localparam logic [K_W-1:0]   LAST_K   = K_W'(`HEX_CHAR_PIXELS - 1);
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(`HEX_COLS - 1);
  localparam logic [2:0]       LAST_SL  = 3'(`HEX_SCANLINES - 1);
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`HEX_ROWS - 1);

  logic [K_W-1:0]   pix_k;  // pixel within the digit
  logic [COL_W-1:0] col;
  logic [2:0]       sl;
  logic [ROW_W-1:0] row;
  logic             started; // low until the first step after reset
  logic [`HEX_DATA_BITS-1:0] snap;

  logic col_last, sl_last, row_last, last_digit;
  logic [COL_W-1:0] fol_col;
  logic [2:0]       fol_sl;
  logic [ROW_W-1:0] fol_row;
  logic [COL_W-1:0] sel_col;
  logic [2:0]       sel_sl;
  logic [ROW_W-1:0] sel_row;
  logic [DIG_W-1:0] sel_idx;
  logic [`HEX_DATA_BITS-1:0] frame_value, sel_value;

  assign col_last   = (col == LAST_COL);
  assign sl_last    = (sl == LAST_SL);
  assign row_last   = (row == LAST_ROW);
  assign last_digit = col_last && sl_last && row_last; // frame wraps after it
  assign char_done  = pixel_step && (pix_k == LAST_K); // spacer pixel step

  // position of the following digit, raster order
  always_comb
  begin
    fol_col = col_last ? '0 : col + 1'b1;
    fol_sl  = sl;
    fol_row = row;
    if (col_last)
    begin
      fol_sl = sl_last ? '0 : sl + 1'b1;
      if (sl_last)
        fol_row = row_last ? '0 : row + 1'b1;
    end
  end

  // serializer is still empty before the first step, so feed it the current digit
  assign sel_col = started ? fol_col : col;
  assign sel_sl  = started ? fol_sl : sl;
  assign sel_row = started ? fol_row : row;

  // value the next frame will show, frozen while hold is set
  assign frame_value = hold ? snap : data_value;
  // first digit of a frame comes from the value about to be snapshotted
  assign sel_value = (started && last_digit) ? frame_value : snap;

  // leftmost column is the most significant nibble of its row
  assign sel_idx = DIG_W'(sel_row) * DIG_W'(`HEX_COLS) + DIG_W'(LAST_COL - sel_col);
  assign next_digit    = sel_value[{sel_idx, 2'b00} +: 4];
  assign next_scanline = sel_sl;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pix_k   <= '0;
      col     <= '0;
      sl      <= '0;
      row     <= '0;
      started <= 1'b0;
      snap    <= '0;
    end
    else if (pixel_step)
    begin
      started <= 1'b1;
      if (pix_k == LAST_K)
      begin
        pix_k <= '0;
        col   <= fol_col;
        sl    <= fol_sl;
        row   <= fol_row;
        if (last_digit)
          snap <= frame_value; // same step loads digit (0,0) into the serializer
      end
      else
        pix_k <= pix_k + 1'b1;
    end
  end

endmodule

// File: design/digit_glyph_decode.sv
// fixed 5x8 font for 0-F plus background lookup, purely combinational
// glyphs are 5x7 with a blank 8th scanline, bit 0 is the left pixel
`timescale 1ns/100ps

module digit_glyph_decode (
  input  hex_pkg::nibble_t      next_digit,
  input  logic [2:0]            next_scanline,
  output hex_pkg::glyph_line_t  next_line,
  output hex_pkg::color_t       next_bg
);

  // one row per digit, scanline 0 first
  // values read mirrored, e.g. 5'h01 lights only the left column
  localparam hex_pkg::glyph_line_t FONT [16][8] = '{
    // 0 with a diagonal stroke
    '{5'h0E, 5'h11, 5'h19, 5'h15,
      5'h13, 5'h11, 5'h0E, 5'h00},
    // 1
    '{5'h04, 5'h06, 5'h04, 5'h04,
      5'h04, 5'h04, 5'h0E, 5'h00},
    // 2
    '{5'h0E, 5'h11, 5'h10, 5'h08,
      5'h04, 5'h02, 5'h1F, 5'h00},
    // 3
    '{5'h1F, 5'h08, 5'h04, 5'h08,
      5'h10, 5'h11, 5'h0E, 5'h00},
    // 4
    '{5'h08, 5'h0C, 5'h0A, 5'h09,
      5'h1F, 5'h08, 5'h08, 5'h00},
    // 5
    '{5'h1F, 5'h01, 5'h0F, 5'h10,
      5'h10, 5'h11, 5'h0E, 5'h00},
    // 6
    '{5'h0C, 5'h02, 5'h01, 5'h0F,
      5'h11, 5'h11, 5'h0E, 5'h00},
    // 7
    '{5'h1F, 5'h10, 5'h08, 5'h04,
      5'h02, 5'h02, 5'h02, 5'h00},
    // 8
    '{5'h0E, 5'h11, 5'h11, 5'h0E,
      5'h11, 5'h11, 5'h0E, 5'h00},
    // 9
    '{5'h0E, 5'h11, 5'h11, 5'h1E,
      5'h10, 5'h08, 5'h06, 5'h00},
    // A
    '{5'h0E, 5'h11, 5'h11, 5'h1F,
      5'h11, 5'h11, 5'h11, 5'h00},
    // B
    '{5'h0F, 5'h11, 5'h11, 5'h0F,
      5'h11, 5'h11, 5'h0F, 5'h00},
    // C
    '{5'h0E, 5'h11, 5'h01, 5'h01,
      5'h01, 5'h11, 5'h0E, 5'h00},
    // D
    '{5'h07, 5'h09, 5'h11, 5'h11,
      5'h11, 5'h09, 5'h07, 5'h00},
    // E
    '{5'h1F, 5'h01, 5'h01, 5'h0F,
      5'h01, 5'h01, 5'h1F, 5'h00},
    // F
    '{5'h1F, 5'h01, 5'h01, 5'h0F,
      5'h01, 5'h01, 5'h01, 5'h00}
  };

  assign next_line = FONT[next_digit][next_scanline];
  assign next_bg   = hex_pkg::BG_COLORS[next_digit]; // colour keyed by digit value

endmodule

// File: design/pixel_serializer.sv
// one registered pixel per pixel_step, latency 1, no back-pressure
// reloads on char_done, i.e. on the spacer step of the digit on screen
`timescale 1ns/100ps

module pixel_serializer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  pixel_step,
  input  logic                  char_done,
  input  hex_pkg::glyph_line_t  next_line,
  input  hex_pkg::color_t       next_bg,
  output hex_pkg::color_t       pixel_color,
  output logic                  pixel_valid
);

  localparam int LINE_W = $bits(hex_pkg::glyph_line_t);

  logic                  loaded;  // set once the first digit is in
  hex_pkg::glyph_line_t  line_q;  // remaining pixels, bit 0 is next
  hex_pkg::color_t       bg_q;
  hex_pkg::glyph_line_t  src_line;
  hex_pkg::color_t       src_bg;

  // until the first step the decode output stands in for the empty register
  assign src_line = loaded ? line_q : next_line;
  assign src_bg   = loaded ? bg_q : next_bg;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      loaded      <= 1'b0;
      pixel_valid <= 1'b0;
    end
    else
    begin
      pixel_valid <= pixel_step; // exactly one valid per step
      if (pixel_step)
        loaded <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pixel_step)
    begin
      pixel_color <= src_line[0] ? hex_pkg::COLOR_WHITE : src_bg;
      if (char_done)
      begin
        line_q <= next_line; // digit after the spacer
        bg_q   <= next_bg;
      end
      else
      begin
        line_q <= {1'b0, src_line[LINE_W-1:1]}; // zero fill, spacer shows bg
        bg_q   <= src_bg;
      end
    end
  end

endmodule

// File: design/hex_display_top.sv
// hex overlay core, wishbone in, one RGB332 pixel per pixel_step out
// pixel order is raster, 2 rows x 16 digits x 8 scanlines x 6 pixels
`timescale 1ns/100ps
`include "hex_config.svh"

module hex_display_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`HEX_WB_ADDR_BITS-1:0]  wb_adr,
  input  logic [31:0]                   wb_dat_w,
  input  logic [3:0]                    wb_sel,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack,
  input  logic                          pixel_step,
  output hex_pkg::color_t               pixel_color,
  output logic                          pixel_valid
);

  logic [`HEX_DATA_BITS-1:0] data_value;
  logic                      hold;
  hex_pkg::nibble_t          next_digit;
  logic [2:0]                next_scanline;
  logic                      char_done;
  hex_pkg::glyph_line_t      next_line;
  hex_pkg::color_t           next_bg;

  wb_hex_regs u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .data_value (data_value),
    .hold       (hold)
  );

  // sequencer runs one digit ahead of the serializer
  glyph_scan_sequencer u_seq (
    .clk           (clk),
    .arst_n        (arst_n),
    .pixel_step    (pixel_step),
    .data_value    (data_value),
    .hold          (hold),
    .next_digit    (next_digit),
    .next_scanline (next_scanline),
    .char_done     (char_done)
  );

  digit_glyph_decode u_decode (
    .next_digit    (next_digit),
    .next_scanline (next_scanline),
    .next_line     (next_line),
    .next_bg       (next_bg)
  );

  pixel_serializer u_ser (
    .clk         (clk),
    .arst_n      (arst_n),
    .pixel_step  (pixel_step),
    .char_done   (char_done),
    .next_line   (next_line),
    .next_bg     (next_bg),
    .pixel_color (pixel_color),
    .pixel_valid (pixel_valid)
  );

endmodule

// File: test/tb_clock_gen.sv
// 100 ns clock, arst_n low for the first two rising edges
// reset is released on a falling edge, away from the sampling edge
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (2) @(posedge clk); // two cycles in reset
    @(negedge clk);
    arst_n = 1'b1;
  end

  always #50 clk = ~clk; // 100 ns period

endmodule

// File: test/hex_display_sva.sv
// bound into hex_display_top, watches the bus and pixel handshakes
// every property is idle while arst_n is low
`timescale 1ns/100ps

module hex_display_sva (
  input logic clk,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic pixel_step,
  input logic pixel_valid
);

  // each step gives a pixel one cycle later
  a_step_valid: assert property (@(posedge clk) disable iff (!arst_n)
    pixel_step |=> pixel_valid)
    else $error("pixel_valid missing one cycle after pixel_step");

  // and no pixel appears without a step
  a_valid_needs_step: assert property (@(posedge clk) disable iff (!arst_n)
    !pixel_step |=> !pixel_valid)
    else $error("pixel_valid without a pixel_step");

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    !(wb_cyc && wb_stb) |=> !wb_ack) // ack only answers a live request
    else $error("wb_ack raised without wb_cyc and wb_stb");

endmodule

// File: test/hex_display_tb.sv
// testbench for hex_display_top, commands and expected pixels come from
// test/hex_display_testdata.txt, so run it from the project root
// a frame test checks its P pixels only in the last frame it steps
`timescale 1ns/100ps
`include "hex_config.svh"

module hex_display_tb;

  localparam int FRAME_LEN = `HEX_ROWS * `HEX_SCANLINES * `HEX_COLS * `HEX_CHAR_PIXELS;
  localparam int ACK_TIMEOUT = 20;  // cycles per bus access
  localparam int RST_TIMEOUT = 10;
  localparam logic [`HEX_WB_ADDR_BITS-1:0] CTRL_ADR = `HEX_WB_ADDR_BITS'(`HEX_DATA_BITS / 32);

  logic clk, arst_n;
  logic wb_cyc, wb_stb, wb_we;
  logic [`HEX_WB_ADDR_BITS-1:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        pixel_step;
  hex_pkg::color_t pixel_color;
  logic        pixel_valid;

  int seed = 92970;     // step gaps
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  bit aborted = 1'b0;   // set on a timeout or a bad file
  hex_pkg::color_t exp_color [FRAME_LEN];
  bit exp_valid [FRAME_LEN];

  tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

  hex_display_top uut (
    .clk(clk), .arst_n(arst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .pixel_step(pixel_step), .pixel_color(pixel_color), .pixel_valid(pixel_valid)
  );

  bind hex_display_top hex_display_sva u_sva (
    .clk(clk), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_ack(wb_ack), .pixel_step(pixel_step), .pixel_valid(pixel_valid)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string what, input int err_before);
    tests_run++;
    if (errors > err_before)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, what, (errors > err_before) ? "FAILED" : "ok");
  endtask

  // one classic cycle, called on a falling edge
  task automatic wb_access(input logic we, input logic [`HEX_WB_ADDR_BITS-1:0] adr,
                           input logic [3:0] sel, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int n;
    int acks;
    n = 0;
    acks = 0;
    rdata = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = wdata;
    while (acks == 0 && n < ACK_TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (wb_ack)
      begin
        acks++;
        rdata = wb_dat_r; // read data comes with ack
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (acks == 0)
    begin
      $display("timeout: no wb_ack within %0d cycles for word %0d", ACK_TIMEOUT, adr);
      errors++;
      aborted = 1'b1;
    end
    else
    begin
      @(negedge clk);
      check("wb_ack", 32'(wb_ack), 32'h0); // a second ack would show here
    end
  endtask

  // steps whole frames at random gaps, gap 0 gives back-to-back steps
  task automatic run_frames(input int frames);
    int gap;
    for (int f = 0; f < frames; f++)
    begin
      for (int idx = 0; idx < FRAME_LEN; idx++)
      begin
        pixel_step = 1'b1;
        @(negedge clk);
        pixel_step = 1'b0;
        check("pixel_valid", 32'(pixel_valid), 32'h1);
        if (f == frames - 1 && exp_valid[idx])
          check($sformatf("pixel_color@%0d", idx), 32'(pixel_color), 32'(exp_color[idx]));
        gap = $unsigned($random(seed)) % 3;
        repeat (gap)
        begin
          @(negedge clk);
          check("pixel_valid", 32'(pixel_valid), 32'h0);
        end
      end
    end
  endtask

  task automatic clear_expected();
    for (int i = 0; i < FRAME_LEN; i++)
      exp_valid[i] = 1'b0;
  endtask

  initial
  begin
    int fd;
    int n;
    int got;
    int want;
    int err0;
    int num;
    string line;
    logic [7:0] cmd;
    logic [`HEX_WB_ADDR_BITS-1:0] adr;
    logic [3:0] sel;
    logic [31:0] dat;
    logic [31:0] rd;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    pixel_step = 1'b0;
    clear_expected();
    fd = 0;
    n = 0;
    while (arst_n !== 1'b1 && n < RST_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (arst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      errors++;
      aborted = 1'b1;
    end
    else
    begin
      err0 = errors;
      check("pixel_valid", 32'(pixel_valid), 32'h0);
      check("wb_ack", 32'(wb_ack), 32'h0);
      report_test("reset outputs", err0);
      fd = $fopen("test/hex_display_testdata.txt", "r");
      if (fd == 0)
      begin
        $display("cannot open test/hex_display_testdata.txt");
        errors++;
        aborted = 1'b1;
      end
    end
    while (!aborted && fd != 0 && !$feof(fd))
    begin
      line = "";
      got = $fgets(line, fd);
      if (got > 0 && $sscanf(line, "%c", cmd) == 1)
      begin
        err0 = errors;
        want = 0;
        got = 0;
        case (cmd)
          "W":
          begin
            got = $sscanf(line, "%c %h %h %h", cmd, adr, sel, dat);
            want = 4;
            wb_access(1'b1, adr, sel, dat, rd);
            report_test($sformatf("write word %0d sel %h", adr, sel), err0);
          end
          "R":
          begin
            got = $sscanf(line, "%c %h %h", cmd, adr, dat);
            want = 3;
            wb_access(1'b0, adr, 4'hF, 32'h0, rd);
            check($sformatf("wb_dat_r word %0d", adr), rd, dat);
            report_test($sformatf("read word %0d", adr), err0);
          end
          "H":
          begin
            got = $sscanf(line, "%c %h", cmd, dat);
            want = 2;
            wb_access(1'b1, CTRL_ADR, 4'h1, {31'b0, dat[0]}, rd);
            wb_access(1'b0, CTRL_ADR, 4'hF, 32'h0, rd);
            check("hold", rd, {31'b0, dat[0]});
            report_test($sformatf("hold %0d", dat[0]), err0);
          end
          "P":
          begin
            got = $sscanf(line, "%c %d %h", cmd, num, dat);
            want = 3;
            if (num >= 0 && num < FRAME_LEN)
            begin
              exp_color[num] = dat[7:0];
              exp_valid[num] = 1'b1;
            end
          end
          "F":
          begin
            got = $sscanf(line, "%c %d", cmd, num);
            want = 2;
            run_frames(num);
            clear_expected();
            report_test($sformatf("%0d frame(s)", num), err0);
          end
          default: ; // comment or blank line
        endcase
        if (got != want)
        begin
          $display("malformed testdata line: %s", line);
          errors++;
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: test/hex_display_testdata.txt
# W adr sel data: write, R adr data: read and compare, H v: set hold (hex fields)
# P index colour: expected pixel (index decimal), F n: step n frames, check P in the last
W 0 F 11111111
W 0 3 0000ABCD
R 0 1111ABCD
W 0 F 89ABCDEF
R 0 89ABCDEF
W 1 F 01234567
W 1 9 AA0000BB
R 1 AA2345BB
W 1 F 01234567
W 2 F 76543210
W 3 F FEDCBA98
R 3 FEDCBA98
R 2 76543210
W 4 2 00000001
R 4 00000000
W 5 F DEADBEEF
R 5 00000000
R 7 00000000
# first frame after reset shows digit 0 on black
P 0 00
P 1 FF
P 5 00
P 1146 FF
P 1147 00
P 1535 00
F 1
# rows read 0123456789ABCDEF and FEDCBA9876543210
P 102 40
P 103 FF
P 107 40
P 382 42
P 1344 FF
P 1345 42
P 1051 00
P 824 FF
P 738 90
F 1
# hold keeps the old value through a write
H 1
W 1 F FFFFFFFF
P 103 FF
P 107 40
F 2
H 0
P 102 FF
P 103 42
P 107 42
P 382 42
F 2

// File: sim.f
+incdir+design
design/hex_pkg.sv
design/wb_hex_regs.sv
design/glyph_scan_sequencer.sv
design/digit_glyph_decode.sv
design/pixel_serializer.sv
design/hex_display_top.sv
test/tb_clock_gen.sv
test/hex_display_sva.sv
test/hex_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the hex overlay testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module hex_display_tb -o hex_display_sim
out=$(./obj_dir/hex_display_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
